// ==== logic/scurvePkg.sv ====
`default_nettype none

package scurvePkg;

  //////////////////////////////////////////////////////////////////////
  // Record tags and fixed words of the USB stream
  //////////////////////////////////////////////////////////////////////
  localparam logic [15:0] HeaderWord   = 16'h5343;  // "SC"
  localparam logic [15:0] TailWord     = 16'hFF45;
  localparam logic [7:0]  TagSingleChn = 8'h43;     // "C"
  localparam logic [7:0]  TagSweepChn  = 8'h63;     // "c"
  localparam logic [3:0]  TagDac       = 4'hD;

  // Length of the Microroc slow-control word handled here
  localparam int ScBits = 266;

  // Run settings, static while a run is active
  typedef struct packed {
    logic       singleChn;    // High for one channel, low for 64-channel sweep
    logic       ctestInject;  // High to inject through Ctest
    logic [5:0] testChn;
  } testParamT;

  // Slow-control word, MSB first on the serial line
  typedef struct packed {
    logic [63:0]  ctestChn;    // One-hot Ctest enable
    logic [9:0]   dacCode;     // Bit-reversed, LSB goes out first
    logic [191:0] discriMask;  // Three bits per channel
  } scParamT;

  typedef struct packed {
    logic [7:0] tag;
    logic [1:0] zero;
    logic [5:0] chn;
  } chnRecT;

  typedef struct packed {
    logic [3:0] tag;
    logic [1:0] zero;
    logic [9:0] code;
  } dacRecT;

  // One USB word, seen as a channel record, a DAC record or plain data
  typedef union packed {
    chnRecT      chnRec;
    dacRecT      dacRec;
    logic [15:0] raw;
  } usbWordU;

endpackage

`default_nettype wire

// ==== logic/scurveTestControl.sv ====
`default_nettype none

module scurveTestControl
  import scurvePkg::*;
#(
  parameter int DacLast    = 1023,
  parameter int LoadSettle = 40000
) (
  input  wire logic      Clk,
  input  wire logic      reset_n,
  input  wire logic      testStart,
  input  wire testParamT testParam,
  input  wire logic      configDone,
  input  wire logic      countDone,
  input  wire logic      fifoEmpty,
  input  wire logic [15:0] fifoData,
  input  wire logic      usbFull,
  input  wire logic      dataTransmitDone,
  output scParamT        scParam,
  output logic           scLoad,
  output logic           countStart,
  output logic           rdEn,
  output usbWordU        usbData,
  output logic           usbWrEn,
  output logic           testDone
);

  localparam int SettleW = $clog2(LoadSettle + 1);

  localparam logic [4:0] Idle       = 5'd0,
                         HeaderOut  = 5'd1,
                         ChnSc      = 5'd2,
                         ChnOut     = 5'd3,
                         DacSc      = 5'd4,
                         DacOut     = 5'd5,
                         WaitLoad   = 5'd6,
                         Settle     = 5'd7,
                         WaitCount  = 5'd8,
                         Drain      = 5'd9,
                         ReadFifo   = 5'd10,
                         LatchCount = 5'd11,
                         OutCount   = 5'd12,
                         NextStep   = 5'd13,
                         NextChn    = 5'd14,
                         TailOut    = 5'd15,
                         TailWait   = 5'd16,
                         Done       = 5'd17;

  logic [4:0]         state;
  logic [5:0]         chn;
  logic [63:0]        ctestMask;  // One-hot, follows chn
  logic [9:0]         dacCode;    // Ramp code, natural bit order
  logic [SettleW-1:0] settleCnt;
  logic [3:0]         idleCnt;

  // The ASIC takes the DAC code LSB first
  function automatic logic [9:0] reverseBits(input logic [9:0] code);
    logic [9:0] rev;
    for (int i = 0; i < 10; i++) begin
      rev[i] = code[9 - i];
    end
    return rev;
  endfunction

  // Records go out straight from their own state, counts wait for space
  assign usbWrEn = (state == HeaderOut) || (state == ChnOut) || (state == DacOut) ||
                   (state == TailOut) || (state == OutCount && !usbFull);

  //////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= Idle;
      chn        <= '0;
      ctestMask  <= 64'd1;
      dacCode    <= '0;
      settleCnt  <= '0;
      idleCnt    <= '0;
      scParam    <= '0;
      scLoad     <= 1'b0;
      countStart <= 1'b0;
      rdEn       <= 1'b0;
      usbData    <= '0;
      testDone   <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          if (testStart) begin
            chn         <= testParam.singleChn ? testParam.testChn : 6'd0;
            ctestMask   <= testParam.singleChn ? (64'd1 << testParam.testChn) : 64'd1;
            dacCode     <= '0;
            usbData.raw <= HeaderWord;
            state       <= HeaderOut;
          end
        end
        HeaderOut: state <= ChnSc;
        ChnSc: begin
          // Channel part of the slow-control word and its record
          scParam.ctestChn   <= testParam.ctestInject ? ctestMask : 64'd0;
          scParam.discriMask <= {189'd0, 3'b111} << (chn * 8'd3);
          usbData.chnRec     <= '{tag:  testParam.singleChn ? TagSingleChn : TagSweepChn,
                                  zero: 2'b00,
                                  chn:  chn};
          state              <= ChnOut;
        end
        ChnOut: state <= DacSc;
        DacSc: begin
          scParam.dacCode <= reverseBits(dacCode);
          usbData.dacRec  <= '{tag: TagDac, zero: 2'b00, code: dacCode};
          state           <= DacOut;
        end
        DacOut: begin
          scLoad <= 1'b1;
          state  <= WaitLoad;
        end
        WaitLoad: begin
          scLoad <= 1'b0;
          if (configDone) begin
            settleCnt <= '0;
            state     <= Settle;
          end
        end
        Settle: begin
          if (settleCnt == SettleW'(LoadSettle - 1)) begin
            countStart <= 1'b1;
            state      <= WaitCount;
          end else begin
            settleCnt <= settleCnt + 1'b1;
          end
        end
        WaitCount: begin
          countStart <= 1'b0;
          if (countDone) state <= Drain;
        end

        ////////////////////////////////////////////////////////////////////
        // Move count words from the FIFO to USB
        ////////////////////////////////////////////////////////////////////
        Drain: begin
          if (fifoEmpty) begin
            state <= NextStep;
          end else begin
            rdEn  <= 1'b1;
            state <= ReadFifo;
          end
        end
        ReadFifo: begin
          rdEn  <= 1'b0;
          state <= LatchCount;
        end
        LatchCount: begin
          usbData.raw <= fifoData;  // FIFO data valid now
          state       <= OutCount;
        end
        OutCount: begin
          if (!usbFull) state <= Drain;  // Held here while USB is full
        end
        NextStep: begin
          if (dacCode == 10'(DacLast)) begin
            dacCode <= '0;
            state   <= NextChn;
          end else begin
            dacCode <= dacCode + 10'd1;
            state   <= DacSc;
          end
        end
        NextChn: begin
          if (testParam.singleChn || chn == 6'd63) begin
            usbData.raw <= TailWord;
            state       <= TailOut;
          end else begin
            chn       <= chn + 6'd1;
            ctestMask <= ctestMask << 1;
            state     <= ChnSc;
          end
        end
        TailOut: begin
          idleCnt <= '0;
          state   <= TailWait;
        end
        TailWait: begin
          if (idleCnt == 4'd15) begin
            testDone <= 1'b1;       // 16 quiet cycles after the tail
            state    <= Done;
          end else begin
            idleCnt <= idleCnt + 4'd1;
          end
        end
        Done: begin
          if (dataTransmitDone) begin
            testDone <= 1'b0;
            state    <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/scurveTop.sv ====
`default_nettype none

module scurveTop
  import scurvePkg::*;
#(
  parameter int DacLast      = 1023,
  parameter int LoadSettle   = 40000,
  parameter int WindowCycles = 1000,
  parameter int FifoDepth    = 16
) (
  input  wire logic      Clk,
  input  wire logic      reset_n,
  input  wire logic      testStart,
  input  wire testParamT testParam,
  input  wire logic      trigger,          // Discriminator output from the ASIC
  input  wire logic      usbFull,
  input  wire logic      dataTransmitDone,
  output usbWordU        usbData,
  output logic           usbWrEn,
  output logic           scSdo,
  output logic           scSck,
  output logic           testDone
);

  scParamT     scParam;
  logic        scLoad;
  logic        configDone;
  logic        countStart;
  logic        countDone;
  logic        cntWrEn;
  logic [15:0] cntWrData;
  logic        rdEn;
  logic [15:0] fifoData;
  logic        fifoEmpty;
  logic        fifoFull;

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////
  scurveTestControl #(
    .DacLast   (DacLast),
    .LoadSettle(LoadSettle)
  ) control0 (
    .Clk(Clk), .reset_n(reset_n),
    .testStart(testStart), .testParam(testParam),
    .configDone(configDone), .countDone(countDone),
    .fifoEmpty(fifoEmpty), .fifoData(fifoData),
    .usbFull(usbFull), .dataTransmitDone(dataTransmitDone),
    .scParam(scParam), .scLoad(scLoad), .countStart(countStart), .rdEn(rdEn),
    .usbData(usbData), .usbWrEn(usbWrEn), .testDone(testDone)
  );

  slowControlLoader loader0 (
    .Clk(Clk), .reset_n(reset_n),
    .scLoad(scLoad), .scParam(scParam),
    .scSdo(scSdo), .scSck(scSck), .configDone(configDone)
  );

  triggerCounter #(.WindowCycles(WindowCycles)) counter0 (
    .Clk(Clk), .reset_n(reset_n),
    .countStart(countStart), .trigger(trigger), .fifoFull(fifoFull),
    .wrEn(cntWrEn), .wrData(cntWrData), .countDone(countDone)
  );

  // Count words between counter and sequencer
  syncFifo #(.Width(16), .Depth(FifoDepth)) fifo0 (
    .Clk(Clk), .reset_n(reset_n),
    .wrEn(cntWrEn), .wrData(cntWrData), .rdEn(rdEn),
    .rdData(fifoData), .empty(fifoEmpty), .full(fifoFull)
  );

endmodule

`default_nettype wire

// ==== logic/slowControlLoader.sv ====
`default_nettype none

module slowControlLoader
  import scurvePkg::*;
(
  input  wire logic    Clk,
  input  wire logic    reset_n,
  input  wire logic    scLoad,
  input  wire scParamT scParam,
  output logic         scSdo,
  output logic         scSck,
  output logic         configDone
);

  localparam int CntW = $clog2(ScBits + 1);

  logic [ScBits-1:0] shiftReg;
  logic [CntW-1:0]   bitsLeft;
  logic              busy;

  //////////////////////////////////////////////////////////////////////
  // Serializer
  // Each bit sits one cycle with clock low, then one cycle with it high
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      shiftReg   <= '0;
      bitsLeft   <= '0;
      busy       <= 1'b0;
      scSck      <= 1'b0;
      configDone <= 1'b0;
    end else begin
      configDone <= 1'b0;
      if (scLoad && !busy) begin
        shiftReg <= scParam;         // Capture whole word
        bitsLeft <= CntW'(ScBits);
        busy     <= 1'b1;
        scSck    <= 1'b0;
      end else if (busy) begin
        if (!scSck) begin
          scSck <= 1'b1;             // Rising edge, ASIC samples here
        end else begin
          scSck <= 1'b0;
          if (bitsLeft == CntW'(1)) begin
            busy       <= 1'b0;
            configDone <= 1'b1;      // Cycle after last high phase
          end else begin
            bitsLeft <= bitsLeft - 1'b1;
            shiftReg <= {shiftReg[ScBits-2:0], 1'b0};
          end
        end
      end
    end
  end

  // MSB first
  assign scSdo = shiftReg[ScBits-1];

endmodule

`default_nettype wire

// ==== logic/syncFifo.sv ====
`default_nettype none

module syncFifo #(
  parameter int Width = 16,
  parameter int Depth = 16
) (
  input  wire logic             Clk,
  input  wire logic             reset_n,
  input  wire logic             wrEn,
  input  wire logic [Width-1:0] wrData,
  input  wire logic             rdEn,
  output logic      [Width-1:0] rdData,
  output logic                  empty,
  output logic                  full
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0]  wrPtr;
  logic [PtrW-1:0]  rdPtr;
  logic [CntW-1:0]  used;
  logic             doWrite;
  logic             doRead;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;  // Wrap for any depth
  endfunction

  assign doWrite = wrEn && !full;   // Write while full is dropped
  assign doRead  = rdEn && !empty;
  assign empty   = (used == '0);
  assign full    = (used == CntW'(Depth));

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      used  <= '0;
    end else begin
      if (doWrite) wrPtr <= nextPtr(wrPtr);
      if (doRead)  rdPtr <= nextPtr(rdPtr);
      case ({doWrite, doRead})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  // Storage and registered read port
  always_ff @(posedge Clk) begin
    if (doWrite) mem[wrPtr] <= wrData;
    if (doRead)  rdData <= mem[rdPtr];  // Valid the cycle after rdEn
  end

endmodule

`default_nettype wire

// ==== logic/triggerCounter.sv ====
`default_nettype none

module triggerCounter #(
  parameter int WindowCycles = 1000
) (
  input  wire logic  Clk,
  input  wire logic  reset_n,
  input  wire logic  countStart,
  input  wire logic  trigger,
  input  wire logic  fifoFull,
  output logic       wrEn,
  output logic [15:0] wrData,
  output logic       countDone
);

  localparam int TimerW = $clog2(WindowCycles + 1);

  logic [TimerW-1:0] timer;    // Cycles left in the window, minus one
  logic              active;
  logic [15:0]       trigCnt;

  //////////////////////////////////////////////////////////////////////
  // Measurement window
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      timer     <= '0;
      active    <= 1'b0;
      trigCnt   <= '0;
      wrEn      <= 1'b0;
      countDone <= 1'b0;
    end else begin
      wrEn      <= 1'b0;
      countDone <= 1'b0;
      if (countStart) begin
        timer   <= TimerW'(WindowCycles - 1);
        active  <= 1'b1;
        trigCnt <= '0;
      end else if (active) begin
        // Saturate instead of wrapping
        if (trigger && trigCnt != 16'hFFFF) begin
          trigCnt <= trigCnt + 16'd1;
        end
        if (timer == '0) begin
          active    <= 1'b0;
          wrEn      <= !fifoFull;
          countDone <= 1'b1;         // Same cycle as the FIFO write
        end else begin
          timer <= timer - 1'b1;
        end
      end
    end
  end

  // Count is final by the time wrEn is high
  assign wrData = trigCnt;

endmodule

`default_nettype wire

// ==== sim/scurveTb.sv ====
`default_nettype none

module scurveTb
  import scurvePkg::*;
();

  localparam int DacLast      = 7;
  localparam int LoadSettle   = 5;
  localparam int WindowCycles = 20;
  localparam int FifoDepth    = 4;
  localparam int StepCycles   = 532 + LoadSettle + WindowCycles + 60;
  localparam int TotalSteps   = (3 + 64) * (DacLast + 1);  // Three single runs and one sweep
  localparam int TimeoutCycles = TotalSteps * StepCycles + 5000;

  logic      Clk = 1'b0;
  logic      reset_n;
  logic      testStart;
  testParamT testParam;
  logic      trigger;
  logic      usbFull;
  logic      dataTransmitDone;
  usbWordU   usbData;
  logic      usbWrEn;
  logic      scSdo;
  logic      scSck;
  logic      testDone;

  logic [31:0]       rngState = 32'hecaa;
  logic [2:0]        thresh [64];  // Per-channel DAC threshold of the ASIC model
  logic [15:0]       expWords [$];
  bit                expIsCount [$];
  int                idx;
  logic [5:0]        curChn;
  logic [9:0]        curCode;
  logic              bpEnable;
  logic [ScBits-1:0] scShift;
  int                nBits;
  int                scChecked;
  logic              prevSck;
  int                errCount;
  int                passCount;
  int                failCount;

  scurveTop #(
    .DacLast(DacLast), .LoadSettle(LoadSettle),
    .WindowCycles(WindowCycles), .FifoDepth(FifoDepth)
  ) dut0 (
    .Clk(Clk), .reset_n(reset_n), .testStart(testStart), .testParam(testParam),
    .trigger(trigger), .usbFull(usbFull), .dataTransmitDone(dataTransmitDone),
    .usbData(usbData), .usbWrEn(usbWrEn), .scSdo(scSdo), .scSck(scSck),
    .testDone(testDone)
  );

  always #20 Clk = ~Clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic reportError(input string msg);
    errCount++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////////////
  function automatic scParamT expectedScWord(input int chn, input int code, input bit inject);
    scParamT w;
    w = '0;
    if (inject) w.ctestChn[chn] = 1'b1;
    for (int i = 0; i < 10; i++) w.dacCode[9 - i] = code[i];  // Code LSB lands on field MSB
    for (int b = 0; b < 3; b++) w.discriMask[3 * chn + b] = 1'b1;
    return w;
  endfunction

  function automatic void buildStream(input testParamT p);
    usbWordU w;
    int      first;
    int      last;
    expWords.delete();
    expIsCount.delete();
    idx = 0;
    first = p.singleChn ? int'(p.testChn) : 0;
    last  = p.singleChn ? int'(p.testChn) : 63;
    expWords.push_back(HeaderWord);
    expIsCount.push_back(1'b0);
    for (int c = first; c <= last; c++) begin
      w.chnRec = '{tag: p.singleChn ? TagSingleChn : TagSweepChn, zero: 2'b00, chn: 6'(c)};
      expWords.push_back(w.raw);
      expIsCount.push_back(1'b0);
      for (int code = 0; code <= DacLast; code++) begin
        w.dacRec = '{tag: TagDac, zero: 2'b00, code: 10'(code)};
        expWords.push_back(w.raw);
        expIsCount.push_back(1'b0);
        expWords.push_back((code < thresh[c]) ? 16'(WindowCycles) : 16'd0);
        expIsCount.push_back(1'b1);
      end
    end
    expWords.push_back(TailWord);
    expIsCount.push_back(1'b0);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // USB compare, ASIC trigger model and serial capture
  //////////////////////////////////////////////////////////////////////
  always @(posedge Clk) begin
    if (reset_n && usbWrEn) begin
      if (idx >= expWords.size()) begin
        reportError($sformatf("extra USB word %h after end of stream", usbData.raw));
      end else begin
        if (usbData.raw !== expWords[idx])
          reportError($sformatf("word %0d is %h, expected %h", idx, usbData.raw, expWords[idx]));
        if (usbFull && expIsCount[idx])
          reportError($sformatf("count word %0d written while USB full", idx));
      end
      if (testDone) reportError("USB word written while testDone high");
      idx++;
      if ((usbData.chnRec.tag == TagSingleChn || usbData.chnRec.tag == TagSweepChn) &&
          usbData.chnRec.zero == 2'b00) begin
        curChn <= usbData.chnRec.chn;
      end
      if (usbData.dacRec.tag == TagDac && usbData.dacRec.zero == 2'b00) begin
        curCode <= usbData.dacRec.code;
        trigger <= (usbData.dacRec.code < thresh[curChn]);  // Steady through the window
      end
    end
  end

  always @(posedge Clk) begin
    usbFull <= bpEnable ? (nextRandom() % 3 == 0) : 1'b0;
  end

  always @(posedge Clk) begin
    if (!reset_n) begin
      prevSck = 1'b0;
      nBits   = 0;
    end else begin
      if (scSck && !prevSck) begin
        scShift = {scShift[ScBits-2:0], scSdo};  // MSB arrives first
        nBits++;
        if (nBits == ScBits) begin
          if (scShift !== expectedScWord(curChn, curCode, testParam.ctestInject))
            reportError($sformatf("slow-control word wrong for chn %0d code %0d",
                                  curChn, curCode));
          nBits = 0;
          scChecked++;
        end
      end
      prevSck = scSck;
    end
  end

  // One full run plus the done handshake
  task automatic runTest(input string name, input testParamT p, input bit backPressure);
    int errBefore;
    int steps;
    int wait4;
    int holdCycles;
    errBefore  = errCount;
    steps      = (p.singleChn ? 1 : 64) * (DacLast + 1);
    holdCycles = 4 + nextRandom() % 8;
    buildStream(p);
    scChecked = 0;
    @(posedge Clk);
    testParam <= p;
    testStart <= 1'b1;
    bpEnable  <= backPressure;
    @(posedge Clk);
    testStart <= 1'b0;
    while (!testDone) @(posedge Clk);   // Watchdog bounds this
    bpEnable <= 1'b0;
    if (idx != expWords.size())
      reportError($sformatf("testDone after %0d words, expected %0d", idx, expWords.size()));
    if (scChecked != steps)
      reportError($sformatf("%0d slow-control loads, expected %0d", scChecked, steps));
    repeat (holdCycles) begin
      @(posedge Clk);
      if (!testDone) reportError("testDone fell before dataTransmitDone");
    end
    dataTransmitDone <= 1'b1;
    wait4 = 0;
    while (testDone && wait4 < 4) begin
      @(posedge Clk);
      wait4++;
    end
    if (testDone) $display("testDone did not fall after dataTransmitDone was raised");
    if (testDone) errCount++;
    dataTransmitDone <= 1'b0;
    if (errCount == errBefore) passCount++;
    else failCount++;
    $display("%s: %s, %0d errors", name, (errCount == errBefore) ? "passed" : "failed",
             errCount - errBefore);
  endtask

  initial begin
    repeat (TimeoutCycles) @(posedge Clk);
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    reset_n          = 1'b0;
    testStart        = 1'b0;
    testParam        = '0;
    trigger          = 1'b0;
    usbFull          = 1'b0;
    dataTransmitDone = 1'b0;
    bpEnable         = 1'b0;
    curChn           = '0;
    curCode          = '0;
    errCount         = 0;
    passCount        = 0;
    failCount        = 0;
    for (int c = 0; c < 64; c++) thresh[c] = 3'(nextRandom() % 8);
    repeat (8) @(posedge Clk);
    reset_n <= 1'b1;
    repeat (2) @(posedge Clk);

    runTest("single channel, Ctest inject",
            '{singleChn: 1'b1, ctestInject: 1'b1, testChn: 6'(nextRandom())}, 1'b0);
    runTest("single channel, input pin, USB back-pressure",
            '{singleChn: 1'b1, ctestInject: 1'b0, testChn: 6'(nextRandom())}, 1'b1);
    runTest("64-channel sweep, USB back-pressure",
            '{singleChn: 1'b0, ctestInject: 1'b1, testChn: 6'd0}, 1'b1);
    runTest("restart after done handshake",
            '{singleChn: 1'b1, ctestInject: 1'b1, testChn: 6'd63}, 1'b0);

    $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/scurvePkg.sv
logic/syncFifo.sv
logic/slowControlLoader.sv
logic/triggerCounter.sv
logic/scurveTestControl.sv
logic/scurveTop.sv
sim/scurveTb.sv
